/* design/matmul_pkg.sv */
package matmul_pkg;

    // element and datapath widths
    typedef logic [1:0] elem_t;
    typedef logic [3:0] prod_t;
    typedef logic [4:0] result_t;     // 0..18 in practice
    typedef logic [3:0] ram_addr_t;
    typedef logic [7:0] ram_data_t;
    typedef logic [1:0] rf_addr_t;
    typedef logic [7:0] bcd_t;        // tens in the upper nibble
    typedef logic [6:0] seg_t;        // a..g, active low

    localparam int        RAM_DEPTH = 12;
    localparam ram_addr_t B_BASE    = 4'd4;
    localparam ram_addr_t C_BASE    = 4'd8;
    localparam int        SCAN_W    = 10;   // 1024 clocks per digit

    typedef enum logic [3:0] {
        seq_idle,
        seq_read_a1,
        seq_load_a1,
        seq_load_a2,
        seq_load_b1,
        seq_load_b2,
        seq_multiply,
        seq_add,
        seq_write,
        seq_update,
        seq_finished
    } seq_state_t;

    typedef enum logic [1:0] {bcd_idle, bcd_shift, bcd_add, bcd_done} bcd_state_t;

    typedef enum logic [1:0] {disp_idle, disp_select, disp_convert, disp_show} disp_state_t;

endpackage

/* design/matrix_loader.sv */
`timescale 1ns/100ps

module matrix_loader (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  btn_left,
    input  logic [15:0]           switches,
    output logic                  load_we,
    output matmul_pkg::ram_addr_t load_addr,
    output matmul_pkg::ram_data_t load_data,
    output logic                  load_done
);

    logic [2:0]          count;        // next switch field, A11 first
    logic [2:0]          field_sel;
    logic                last_wr;
    logic                take;
    matmul_pkg::elem_t   field;

    assign field_sel = 3'd7 - count;                  // A11 sits in switches[15:14]
    assign field     = switches[{field_sel, 1'b0} +: 2];
    assign last_wr   = load_we && (load_addr == matmul_pkg::ram_addr_t'(7));
    assign take      = btn_left && !load_done && !last_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            load_we   <= 1'b0;
            load_addr <= '0;
            load_done <= 1'b0;
        end else begin
            load_we <= take;              // releasing the button pauses here
            if (take) begin
                count     <= count + 3'd1;  // wraps after B22, take blocks it then
                load_addr <= {1'b0, count};
            end
            if (last_wr)
                load_done <= 1'b1;        // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            load_data <= {6'b000000, field};
    end

    a_no_write_after_done: assert property (@(posedge clk) disable iff (rst)
        load_done |-> !load_we);

endmodule

/* design/operand_ram.sv */
`timescale 1ns/100ps

module operand_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_done,
    input  logic                  load_we,
    input  matmul_pkg::ram_addr_t load_addr,
    input  matmul_pkg::ram_data_t load_data,
    input  logic                  seq_we,
    input  matmul_pkg::ram_addr_t seq_addr,
    input  matmul_pkg::ram_data_t seq_wdata,
    output matmul_pkg::ram_data_t rd_data
);

    matmul_pkg::ram_data_t mem [matmul_pkg::RAM_DEPTH];
    logic                  we;
    matmul_pkg::ram_addr_t addr;
    matmul_pkg::ram_data_t wdata;

    // loader owns the port until the operands are in
    assign we    = load_done ? seq_we    : load_we;
    assign addr  = load_done ? seq_addr  : load_addr;
    assign wdata = load_done ? seq_wdata : load_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < matmul_pkg::RAM_DEPTH; i++)
                mem[i] <= '0;
        end else if (we) begin
            mem[addr] <= wdata;
        end else begin
            rd_data <= mem[addr];    // one clock read latency
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        addr < matmul_pkg::RAM_DEPTH);

endmodule

/* design/product_sequencer.sv */
`timescale 1ns/100ps

module product_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  btn_right,
    input  logic                  load_done,
    input  matmul_pkg::ram_data_t rd_data,
    input  matmul_pkg::result_t   sum,
    output logic                  seq_we,
    output matmul_pkg::ram_addr_t seq_addr,
    output matmul_pkg::ram_data_t seq_wdata,
    output logic                  rf_we,
    output matmul_pkg::rf_addr_t  rf_waddr,
    output logic                  acc_en,
    output logic                  acc_clear,
    output logic                  results_valid,
    output matmul_pkg::result_t   c11,
    output matmul_pkg::result_t   c12,
    output matmul_pkg::result_t   c21,
    output matmul_pkg::result_t   c22
);

    matmul_pkg::seq_state_t state;
    matmul_pkg::seq_state_t state_nxt;
    logic [1:0]             idx;          // {row, col} of the result element
    matmul_pkg::ram_addr_t  a1_addr;
    matmul_pkg::ram_addr_t  a2_addr;
    matmul_pkg::ram_addr_t  b1_addr;
    matmul_pkg::ram_addr_t  b2_addr;

    assign a1_addr = {2'b00, idx[1], 1'b0};
    assign a2_addr = {2'b00, idx[1], 1'b1};
    assign b1_addr = matmul_pkg::B_BASE + {3'b000, idx[0]};
    assign b2_addr = matmul_pkg::B_BASE + {3'b001, idx[0]};   // second row of B

    assign seq_wdata     = {3'b000, sum};
    assign results_valid = (state == matmul_pkg::seq_finished);
    // unused RAM data bits are read by the dot product unit, not here
    assign rf_waddr      = matmul_pkg::rf_addr_t'(state - matmul_pkg::seq_load_a1);

    ////////////////////////////////////////
    // state sequencing, nine cycles per element
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= matmul_pkg::seq_idle;
            idx   <= '0;
        end else begin
            state <= state_nxt;
            if (state == matmul_pkg::seq_update)
                idx <= idx + 2'd1;
        end
    end

    always_comb begin
        state_nxt = matmul_pkg::seq_state_t'(state + 4'd1);
        case (state)
            matmul_pkg::seq_idle:
                state_nxt = (btn_right && load_done) ? matmul_pkg::seq_read_a1
                                                     : matmul_pkg::seq_idle;
            matmul_pkg::seq_update:
                state_nxt = (idx == 2'd3) ? matmul_pkg::seq_finished
                                          : matmul_pkg::seq_read_a1;
            matmul_pkg::seq_finished: state_nxt = matmul_pkg::seq_finished;  // holds
            default: ;
        endcase
    end

    always_comb begin
        seq_we    = 1'b0;
        seq_addr  = '0;
        rf_we     = 1'b0;
        acc_en    = 1'b0;
        acc_clear = 1'b0;
        case (state)
            matmul_pkg::seq_read_a1: seq_addr = a1_addr;
            matmul_pkg::seq_load_a1: begin
                rf_we    = 1'b1;
                seq_addr = a2_addr;
            end
            matmul_pkg::seq_load_a2: begin
                rf_we    = 1'b1;
                seq_addr = b1_addr;
            end
            matmul_pkg::seq_load_b1: begin
                rf_we    = 1'b1;
                seq_addr = b2_addr;
            end
            matmul_pkg::seq_load_b2: rf_we = 1'b1;
            matmul_pkg::seq_add:     acc_en = 1'b1;
            matmul_pkg::seq_write: begin
                seq_we   = 1'b1;
                seq_addr = matmul_pkg::C_BASE + {2'b00, idx};
            end
            matmul_pkg::seq_update:  acc_clear = 1'b1;
            default: ;
        endcase
    end

    // local copy of C for the display
    always_ff @(posedge clk) begin
        if (state == matmul_pkg::seq_write) begin
            case (idx)
                2'd0: c11 <= sum;
                2'd1: c12 <= sum;
                2'd2: c21 <= sum;
                default: c22 <= sum;
            endcase
        end
    end

    a_rf_quiet_in_idle: assert property (@(posedge clk) disable iff (rst)
        (state == matmul_pkg::seq_idle) |-> !rf_we);

endmodule

/* design/dot_product_unit.sv */
`timescale 1ns/100ps

module dot_product_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rf_we,
    input  matmul_pkg::rf_addr_t  rf_waddr,
    input  matmul_pkg::ram_data_t rd_data,
    input  logic                  acc_en,
    input  logic                  acc_clear,
    output matmul_pkg::result_t   sum
);

    // entries: 0 = A row elem 1, 1 = A row elem 2, 2 = B col elem 1, 3 = B col elem 2
    matmul_pkg::elem_t rf [4];
    matmul_pkg::prod_t p0;
    matmul_pkg::prod_t p1;

    always_ff @(posedge clk) begin
        if (rf_we)
            rf[rf_waddr] <= rd_data[1:0];   // RAM words are zero padded
    end

    assign p0 = rf[0] * rf[2];
    assign p1 = rf[1] * rf[3];

    ////////////////////////////////////////
    // sum register
    always_ff @(posedge clk) begin
        if (rst || acc_clear)
            sum <= '0;
        else if (acc_en)
            sum <= {1'b0, p0} + {1'b0, p1};   // carry into bit 4
    end

endmodule

/* design/bcd_converter.sv */
`timescale 1ns/100ps

module bcd_converter (
    input  logic                clk,
    input  logic                rst,
    input  logic                conv_start,
    input  matmul_pkg::result_t bin_in,
    output matmul_pkg::bcd_t    bcd_out,
    output logic                conv_done
);

    matmul_pkg::bcd_state_t state;
    logic [12:0]            work;      // tens, ones, binary
    logic [2:0]             shifts;

    function automatic logic [3:0] add3(input logic [3:0] d);
        return (d > 4'd4) ? d + 4'd3 : d;
    endfunction

    assign conv_done = (state == matmul_pkg::bcd_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= matmul_pkg::bcd_idle;
            shifts <= '0;
        end else begin
            case (state)
                matmul_pkg::bcd_idle:
                    if (conv_start) begin
                        state  <= matmul_pkg::bcd_shift;   // digits start at zero
                        shifts <= '0;
                    end
                matmul_pkg::bcd_add: state <= matmul_pkg::bcd_shift;
                matmul_pkg::bcd_shift: begin
                    shifts <= shifts + 3'd1;
                    state  <= (shifts == 3'd4) ? matmul_pkg::bcd_done : matmul_pkg::bcd_add;
                end
                default: state <= matmul_pkg::bcd_idle;    // done lasts one clock
            endcase
        end
    end

    ////////////////////////////////////////
    // shift-and-add-3 datapath
    always_ff @(posedge clk) begin
        case (state)
            matmul_pkg::bcd_idle:
                if (conv_start)
                    work <= {8'h00, bin_in};
            matmul_pkg::bcd_add: begin
                work[12:9] <= add3(work[12:9]);
                work[8:5]  <= add3(work[8:5]);
            end
            matmul_pkg::bcd_shift: begin
                work <= {work[11:0], 1'b0};
                if (shifts == 3'd4)
                    bcd_out <= work[11:4];    // digits after the last shift
            end
            default: ;
        endcase
    end

    a_digits_decimal: assert property (@(posedge clk) disable iff (rst)
        conv_done |-> (bcd_out[7:4] <= 4'd9) && (bcd_out[3:0] <= 4'd9));

endmodule

/* design/result_display.sv */
`timescale 1ns/100ps

module result_display (
    input  logic                clk,
    input  logic                rst,
    input  logic                results_valid,
    input  logic                btn_up,
    input  logic                btn_left,
    input  logic                btn_right,
    input  logic                btn_down,
    input  matmul_pkg::result_t c11,
    input  matmul_pkg::result_t c12,
    input  matmul_pkg::result_t c21,
    input  matmul_pkg::result_t c22,
    input  matmul_pkg::bcd_t    bcd_out,
    input  logic                conv_done,
    output logic                conv_start,
    output matmul_pkg::result_t bin_in,
    output logic [3:0]          anode,
    output matmul_pkg::seg_t    seg,
    output logic                dp
);

    matmul_pkg::disp_state_t        state;
    matmul_pkg::result_t            pick;
    matmul_pkg::bcd_t               digits;
    logic                           digits_valid;
    logic                           press;
    logic                           blank;
    logic [3:0]                     digit;
    logic [matmul_pkg::SCAN_W-1:0]  scan_cnt;

    function automatic matmul_pkg::seg_t seg_of(input logic [3:0] d);
        case (d)    // a..g, low lights the segment
            4'd0:    return 7'b0000001;
            4'd1:    return 7'b1001111;
            4'd2:    return 7'b0010010;
            4'd3:    return 7'b0000110;
            4'd4:    return 7'b1001100;
            4'd5:    return 7'b0100100;
            4'd6:    return 7'b0100000;
            4'd7:    return 7'b0001111;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0001100;
            default: return 7'b1111111;
        endcase
    endfunction

    // up, left, right, down in priority order
    assign pick = btn_up   ? c11 :
                  btn_left ? c12 :
                  btn_right ? c21 : c22;
    assign press = results_valid && (btn_up || btn_left || btn_right || btn_down)
                   && (state == matmul_pkg::disp_idle || state == matmul_pkg::disp_show);
    assign conv_start = (state == matmul_pkg::disp_select);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= matmul_pkg::disp_idle;
            digits_valid <= 1'b0;
        end else if (press) begin
            state <= matmul_pkg::disp_select;
        end else if (state == matmul_pkg::disp_select) begin
            state <= matmul_pkg::disp_convert;
        end else if (state == matmul_pkg::disp_convert && conv_done) begin
            state        <= matmul_pkg::disp_show;
            digits_valid <= 1'b1;   // old digits stay up meanwhile
        end
    end

    always_ff @(posedge clk) begin
        if (press)
            bin_in <= pick;
        if (state == matmul_pkg::disp_convert && conv_done)
            digits <= bcd_out;
    end

    ////////////////////////////////////////
    // digit scan, active-low anodes
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
            anode    <= 4'b1110;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            if (&scan_cnt)
                anode <= {anode[2:0], anode[3]};
        end
    end

    assign blank = !digits_valid || !anode[2] || !anode[3];   // upper two digits stay dark
    assign digit = anode[0] ? digits[7:4] : digits[3:0];
    assign seg   = blank ? 7'b1111111 : seg_of(digit);
    assign dp    = 1'b1;

endmodule

/* design/matmul_top.sv */
`timescale 1ns/100ps

module matmul_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             btn_up,
    input  logic             btn_left,
    input  logic             btn_right,
    input  logic             btn_down,
    input  logic [15:0]      switches,
    output matmul_pkg::seg_t seg,
    output logic             dp,
    output logic [3:0]       anode,
    output logic             load_done,
    output logic             fsm_done
);

    // load stage to RAM
    logic                  load_we;
    matmul_pkg::ram_addr_t load_addr;
    matmul_pkg::ram_data_t load_data;

    // compute stage
    logic                  seq_we;
    matmul_pkg::ram_addr_t seq_addr;
    matmul_pkg::ram_data_t seq_wdata;
    matmul_pkg::ram_data_t rd_data;
    logic                  rf_we;
    matmul_pkg::rf_addr_t  rf_waddr;
    logic                  acc_en;
    logic                  acc_clear;
    matmul_pkg::result_t   sum;
    matmul_pkg::result_t   c11;
    matmul_pkg::result_t   c12;
    matmul_pkg::result_t   c21;
    matmul_pkg::result_t   c22;

    // convert and display stage
    logic                  conv_start;
    logic                  conv_done;
    matmul_pkg::result_t   bin_in;
    matmul_pkg::bcd_t      bcd_out;

    matrix_loader u_loader (
        .clk, .rst, .btn_left, .switches,
        .load_we, .load_addr, .load_data, .load_done
    );

    operand_ram u_ram (
        .clk, .rst, .load_done, .load_we, .load_addr, .load_data,
        .seq_we, .seq_addr, .seq_wdata, .rd_data
    );

    product_sequencer u_seq (
        .clk, .rst, .btn_right, .load_done, .rd_data, .sum,
        .seq_we, .seq_addr, .seq_wdata, .rf_we, .rf_waddr, .acc_en, .acc_clear,
        .results_valid(fsm_done), .c11, .c12, .c21, .c22
    );

    dot_product_unit u_dot (
        .clk, .rst, .rf_we, .rf_waddr, .rd_data, .acc_en, .acc_clear, .sum
    );

    bcd_converter u_bcd (
        .clk, .rst, .conv_start, .bin_in, .bcd_out, .conv_done
    );

    result_display u_disp (
        .clk, .rst, .results_valid(fsm_done),
        .btn_up, .btn_left, .btn_right, .btn_down,
        .c11, .c12, .c21, .c22, .bcd_out, .conv_done,
        .conv_start, .bin_in, .anode, .seg, .dp
    );

endmodule

/* testbench/tb_matmul.sv */
`timescale 1ns/100ps

module tb_matmul;

    localparam int LOAD_LIMIT = 20;
    localparam int RUN_LIMIT  = 60;
    localparam int SCAN_LIMIT = 5000;   // a full scan is 4 x 1024 clocks

    logic             clk;
    logic             rst;
    logic             btn_up;
    logic             btn_left;
    logic             btn_right;
    logic             btn_down;
    logic [15:0]      switches;
    matmul_pkg::seg_t seg;
    logic             dp;
    logic [3:0]       anode;
    logic             load_done;
    logic             fsm_done;

    int               c_ref [4];      // expected C11, C12, C21, C22
    logic [3:0]       exp_ones;
    logic [3:0]       exp_tens;
    logic             check_digits;   // digits of the current pick are up
    logic [31:0]      rnd;

    matmul_top UUT (
        .clk, .rst, .btn_up, .btn_left, .btn_right, .btn_down, .switches,
        .seg, .dp, .anode, .load_done, .fsm_done
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic flag_mismatch(input string what);
        stop_run($sformatf("[FAIL] %0t ns: %s", $time, what));
    endtask

    // a..g with a in bit 6, low lights the segment
    function automatic matmul_pkg::seg_t seg_code(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b0000001;
            4'd1:    return 7'b1001111;
            4'd2:    return 7'b0010010;
            4'd3:    return 7'b0000110;
            4'd4:    return 7'b1001100;
            4'd5:    return 7'b0100100;
            4'd6:    return 7'b0100000;
            4'd7:    return 7'b0001111;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0001100;
            default: return 7'b1111111;
        endcase
    endfunction

    ////////////////////////////////////////
    // checkers
    a_ones_digit: assert property (@(posedge clk) disable iff (rst)
        (check_digits && anode == 4'b1110) |-> seg == seg_code(exp_ones))
        else flag_mismatch($sformatf("ones digit wrong, expected %0d", exp_ones));

    a_tens_digit: assert property (@(posedge clk) disable iff (rst)
        (check_digits && anode == 4'b1101) |-> seg == seg_code(exp_tens))
        else flag_mismatch($sformatf("tens digit wrong, expected %0d", exp_tens));

    a_upper_blank: assert property (@(posedge clk) disable iff (rst)
        (anode == 4'b1011 || anode == 4'b0111) |-> seg == 7'b1111111)
        else flag_mismatch("upper digit not blank");

    a_dp_high: assert property (@(posedge clk) dp)
        else flag_mismatch("dp went low");

    a_load_done_holds: assert property (@(posedge clk) disable iff (rst)
        load_done |=> load_done)
        else flag_mismatch("load_done dropped before reset");

    a_fsm_done_holds: assert property (@(posedge clk) disable iff (rst)
        fsm_done |=> fsm_done)
        else flag_mismatch("fsm_done dropped before reset");

    // C = A x B from the switch fields, A11 in the top two bits
    task automatic compute_reference(input logic [15:0] sw);
        int a [4];
        int b [4];
        for (int i = 0; i < 4; i++) begin
            a[i] = int'(sw[15 - 2 * i -: 2]);
            b[i] = int'(sw[7 - 2 * i -: 2]);
        end
        c_ref[0] = a[0] * b[0] + a[1] * b[2];
        c_ref[1] = a[0] * b[1] + a[1] * b[3];
        c_ref[2] = a[2] * b[0] + a[3] * b[2];
        c_ref[3] = a[2] * b[1] + a[3] * b[3];
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst          <= 1'b1;
        check_digits <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (load_done == 1'b0) else flag_mismatch("load_done high after reset");
        assert (fsm_done == 1'b0) else flag_mismatch("fsm_done high after reset");
        assert (anode == 4'b1110) else flag_mismatch("anode not 1110 after reset");
        assert (seg == 7'b1111111) else flag_mismatch("segments lit after reset");
    endtask

    // right press with no operands loaded
    task automatic press_start_early();
        @(posedge clk);
        btn_right <= 1'b1;
        @(posedge clk);
        btn_right <= 1'b0;
        for (int n = 0; n < 50; n++) begin
            @(negedge clk);
            assert (!fsm_done) else flag_mismatch("fsm_done rose before loading");
        end
    endtask

    task automatic load_operands(input logic [15:0] value);
        int cycles;
        cycles = 0;
        compute_reference(value);
        @(posedge clk);
        switches <= value;
        btn_left <= 1'b1;
        while (!load_done) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (cycles > LOAD_LIMIT)
                stop_run("load_done never rose while the left button was held");
        end
        assert (cycles <= 9)
            else flag_mismatch($sformatf("load_done after %0d cycles", cycles));
        // keep holding with new switches, operands must not change
        @(posedge clk);
        rnd = $urandom;
        switches <= rnd[15:0];
        repeat (4) @(posedge clk);
        btn_left <= 1'b0;
    endtask

    task automatic run_compute();
        int cycles;
        cycles = 0;
        @(posedge clk);
        btn_right <= 1'b1;
        while (!fsm_done) begin
            @(posedge clk);
            cycles++;
            if (cycles == 1)
                btn_right <= 1'b0;
            @(negedge clk);
            if (cycles > RUN_LIMIT)
                stop_run("fsm_done never rose after the start press");
        end
        assert (cycles == 37)
            else flag_mismatch($sformatf("fsm_done after %0d cycles, expected 37", cycles));
    endtask

    task automatic wait_anode(input logic [3:0] target);
        int n;
        n = 0;
        @(negedge clk);
        while (anode != target) begin
            @(negedge clk);
            n++;
            if (n > SCAN_LIMIT)
                stop_run($sformatf("anode never reached %b", target));
        end
    endtask

    // which: 0 up, 1 left, 2 right, 3 down
    task automatic check_element(input int which);
        int value;
        value = c_ref[which];
        @(posedge clk);
        check_digits <= 1'b0;
        exp_ones     <= 4'(value % 10);
        exp_tens     <= 4'(value / 10);
        btn_up       <= (which == 0);
        btn_left     <= (which == 1);
        btn_right    <= (which == 2);
        btn_down     <= (which == 3);
        @(posedge clk);
        btn_up    <= 1'b0;
        btn_left  <= 1'b0;
        btn_right <= 1'b0;
        btn_down  <= 1'b0;
        repeat (16) @(posedge clk);   // conversion latency
        check_digits <= 1'b1;
        wait_anode(4'b1110);
        wait_anode(4'b1101);
        wait_anode(4'b1011);
        wait_anode(4'b0111);
    endtask

    task automatic run_matrix_pair();
        rnd = $urandom;
        load_operands(rnd[15:0]);
        run_compute();
        for (int which = 0; which < 4; which++)
            check_element(which);
    endtask

    ////////////////////////////////////////
    // main sequence
    initial begin
        rst          = 1'b1;
        btn_up       = 1'b0;
        btn_left     = 1'b0;
        btn_right    = 1'b0;
        btn_down     = 1'b0;
        switches     = '0;
        check_digits = 1'b0;
        exp_ones     = '0;
        exp_tens     = '0;
        rnd          = $urandom(32'he75f29bd);
        apply_reset();
        press_start_early();
        run_matrix_pair();
        apply_reset();            // second pair from a fresh start
        run_matrix_pair();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* flist.f */
design/matmul_pkg.sv
design/matrix_loader.sv
design/operand_ram.sv
design/product_sequencer.sv
design/dot_product_unit.sv
design/bcd_converter.sv
design/result_display.sv
design/matmul_top.sv
testbench/tb_matmul.sv

/* Makefile */
TOP = tb_matmul

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f design/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only -Wall --timing --top-module matmul_top -f flist.f

clean:
	rm -rf obj_dir
